/* verilog/ccu_pkg.sv */
/*
 * Common definitions for the order and clear control units.
 * Word timing of the delay-line store, the 5-bit order letter codes,
 * the transfer control levels and the digit counter type.
 */
package ccu_pkg;

   // Word timing.
   localparam int DIGITS_PER_MINOR = 18;  // Digit positions in one minor cycle.
   localparam int DIGIT_W          = 5;   // Enough bits to count 0..17.

   // Order letters travel as 5-bit teleprinter codes.
   localparam int ORDER_W = 5;

   typedef logic [DIGIT_W-1:0] digit_t;  // Digit position within a minor cycle.

   // Order letters, coded as on the machine's teleprinter.
   // Only T, U and H drive the tank clear logic.
   typedef enum logic [ORDER_W-1:0] {
      ORD_NONE = 5'd0,   // No order held.
      ORD_T    = 5'd5,   // Transfer to store and clear Accumulator.
      ORD_U    = 5'd7,   // Transfer to store, Accumulator retained.
      ORD_S    = 5'd12,  // Subtract.
      ORD_Z    = 5'd13,  // Stop.
      ORD_H    = 5'd21,  // Store word to Multiplier.
      ORD_A    = 5'd28,  // Add.
      ORD_V    = 5'd31   // Multiply and add.
   } order_code_t;

   // Transfer control levels decoded from the held order.
   typedef struct packed {
      logic c18;   // H order, store to Multiplier.
      logic c19;   // T or U order, Accumulator to store.
      logic c20;   // T order, transfer and clear.
      logic op_u;  // U order, transfer without clearing.
   } order_ctrl_t;

endpackage

/* verilog/digit_timer.sv */
/*
 * Digit timer.
 * Counts digit positions within each minor cycle and tracks minor-cycle
 * parity. Marks digit 0 of even and odd minor cycles with one-cycle strobes.
 */
`timescale 1ns/1ps

module digit_timer (
   input  logic clk,     // Digit clock.
   input  logic rst_n,   // Asynchronous reset, active low.
   output logic ev_d0,   // Digit 0 of an even minor cycle.
   output logic odd_d0   // Digit 0 of an odd minor cycle.
);

   ccu_pkg::digit_t digit;  // Current digit position.
   logic            odd;    // Minor cycle parity, high in odd cycles.
   logic            wrap;   // Last digit of the minor cycle.
   logic            d0;     // Digit 0 of any minor cycle.

   assign wrap = (digit == ccu_pkg::digit_t'(ccu_pkg::DIGITS_PER_MINOR - 1));  // Digit 17.
   assign d0   = (digit == '0);

   // Digit counter and parity flop.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         digit <= '0;              // Start at digit 0.
         odd   <= 1'b0;            // of an even minor cycle.
      end else if (wrap) begin
         digit <= '0;              // Back to digit 0.
         odd   <= ~odd;            // Next minor cycle.
      end else begin
         digit <= digit + 1'b1;    // Next digit position.
      end
   end

   // Strobes come straight from the count, so ev_d0 is up
   // in the first cycle out of reset.
   assign ev_d0  = d0 & ~odd;  // Even minor cycle start.
   assign odd_d0 = d0 & odd;   // Odd minor cycle start.

   // The two strobes mark different minor cycles.
   a_strobe_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ev_d0 && odd_d0)
   ) else $error("digit_timer: ev_d0 and odd_d0 high together");

endmodule

/* verilog/order_decode.sv */
/*
 * Order decoder.
 * Holds the current order letter and turns it into the transfer control
 * levels c18, c19, c20 and the U-order flag for the clear control.
 */
`timescale 1ns/1ps

module order_decode (
   input  logic                  clk,         // Digit clock.
   input  logic                  rst_n,       // Asynchronous reset, active low.
   input  logic                  order_load,  // Load strobe for a new order.
   input  ccu_pkg::order_code_t  order_code,  // Order letter from the order tank.
   output ccu_pkg::order_ctrl_t  ctrl         // Transfer control levels.
);

   ccu_pkg::order_code_t order_q;  // Held order.

   // Order register.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         order_q <= ccu_pkg::ORD_NONE;  // No order after reset.
      end else if (order_load) begin
         order_q <= order_code;         // Take the new order.
      end
   end

   // Decode the held order.
   // Levels change the cycle after a load and hold until the next one.
   always_comb begin
      case (order_q)
         ccu_pkg::ORD_T: begin
            // Store and clear Accumulator.
            ctrl = '{c18: 1'b0, c19: 1'b1, c20: 1'b1, op_u: 1'b0};
         end
         ccu_pkg::ORD_U: begin
            // Store, Accumulator kept.
            ctrl = '{c18: 1'b0, c19: 1'b1, c20: 1'b0, op_u: 1'b1};
         end
         ccu_pkg::ORD_H: begin
            // Word into Multiplier.
            ctrl = '{c18: 1'b1, c19: 1'b0, c20: 1'b0, op_u: 1'b0};
         end
         default: begin
            ctrl = '0;  // Not a transfer order.
         end
      endcase
   end

   // Clearing and retaining transfers exclude each other.
   a_t_u_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ctrl.c20 && ctrl.op_u)
   ) else $error("order_decode: c20 and op_u high together");

endmodule

/* verilog/tank_clear_control.sv */
/*
 * Tank clear control.
 * On r2 or s2 during a transfer order, clears the Accumulator, Multiplier
 * and Multiplicand for one minor cycle through gates g9, g10 and g11,
 * then issues end pulse ep6 (store and clear) or ep7 (store and retain).
 */
`timescale 1ns/1ps

module tank_clear_control (
   input  logic                  clk,      // Digit clock.
   input  logic                  rst_n,    // Asynchronous reset, active low.
   input  ccu_pkg::order_ctrl_t  ctrl,     // Transfer control levels.
   input  logic                  ev_d0,    // Digit 0, even minor cycle.
   input  logic                  odd_d0,   // Digit 0, odd minor cycle.
   input  logic                  r2,       // MCU coincidence.
   input  logic                  s2,       // Stimulating pulse.
   output logic                  ep6,      // End pulse, store and clear.
   output logic                  ep7,      // End pulse, store and retain.
   output logic                  g9_neg,   // Accumulator clear gate, active low.
   output logic                  g10_neg,  // Multiplier clear gate, active low.
   output logic                  g11_neg   // Multiplicand clear gate, active low.
);

   logic ep7_set;    // Start of a transfer.
   logic ep7_reset;  // End of the clear minor cycle.
   logic clr_set;    // Clear window opens.
   logic ep7_ff;     // Transfer pending.
   logic clr_ff;     // Clear window open.
   logic op_u_d;     // op_u one cycle late.
   logic ep7_ff_d;   // ep7_ff one cycle late.

   assign ep7_set   = (r2 & ctrl.c19) | (s2 & ctrl.c18);  // Transfer to or from store.
   assign ep7_reset = ev_d0 & clr_ff;                     // Clear window done.
   assign clr_set   = odd_d0 & ep7_ff;                    // Wait for an odd minor cycle.

   // Transfer pending flop. Reset wins over set,
   // so a late r2 or s2 in the closing cycle is dropped.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ep7_ff <= 1'b0;
      end else if (ep7_reset) begin
         ep7_ff <= 1'b0;  // Sequence finished.
      end else if (ep7_set) begin
         ep7_ff <= 1'b1;  // Repeats while set are absorbed.
      end
   end

   // Clear window flop, open from digit 1 of the odd minor cycle
   // through digit 0 of the following even one.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         clr_ff <= 1'b0;
      end else if (ev_d0) begin
         clr_ff <= 1'b0;  // Close at the next even digit 0.
      end else if (clr_set) begin
         clr_ff <= 1'b1;  // Open after odd digit 0.
      end
   end

   // Delay cells feeding the ep7 gate.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op_u_d   <= 1'b0;
         ep7_ff_d <= 1'b0;
      end else begin
         op_u_d   <= ctrl.op_u;
         ep7_ff_d <= ep7_ff;
      end
   end

   // Clear gates, low while the window is open.
   assign g11_neg = ~clr_ff;                // Multiplicand, every transfer.
   assign g9_neg  = ~(clr_ff & ctrl.c20);   // Accumulator, T order only.
   assign g10_neg = ~(clr_ff & ctrl.c18);   // Multiplier, H order only.

   // End pulses in the last cycle of the window.
   assign ep6 = ev_d0 & ~g9_neg;                       // T order.
   assign ep7 = ev_d0 & clr_ff & op_u_d & ep7_ff_d;    // U order.

   // The window only opens on a pending transfer.
   a_clr_needs_ep7: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(clr_ff) |-> $past(ep7_ff)
   ) else $error("tank_clear_control: clear flop set without ep7 flop");

   // A transfer ends with one kind of end pulse only.
   a_end_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ep6 && ep7)
   ) else $error("tank_clear_control: ep6 and ep7 high together");

endmodule

/* verilog/order_control_top.sv */
/*
 * Order and tank clear control.
 * Digit timer, order decoder and tank clear control side by side.
 */
`timescale 1ns/1ps

module order_control_top (
   input  logic                  clk,         // Digit clock.
   input  logic                  rst_n,       // Asynchronous reset, active low.
   input  logic                  order_load,  // Load strobe for a new order.
   input  ccu_pkg::order_code_t  order_code,  // Order letter.
   input  logic                  r2,          // MCU coincidence.
   input  logic                  s2,          // Stimulating pulse.
   output logic                  ev_d0,       // Digit 0, even minor cycle.
   output logic                  odd_d0,      // Digit 0, odd minor cycle.
   output logic                  ep6,         // End pulse, store and clear.
   output logic                  ep7,         // End pulse, store and retain.
   output logic                  g9_neg,      // Accumulator clear gate.
   output logic                  g10_neg,     // Multiplier clear gate.
   output logic                  g11_neg      // Multiplicand clear gate.
);

   ccu_pkg::order_ctrl_t ctrl;  // Decoded transfer levels.

   digit_timer digit_timer_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .ev_d0  (ev_d0),
      .odd_d0 (odd_d0)
   );

   order_decode order_decode_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .order_load (order_load),
      .order_code (order_code),
      .ctrl       (ctrl)
   );

   tank_clear_control tank_clear_control_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .ctrl    (ctrl),
      .ev_d0   (ev_d0),
      .odd_d0  (odd_d0),
      .r2      (r2),
      .s2      (s2),
      .ep6     (ep6),
      .ep7     (ep7),
      .g9_neg  (g9_neg),
      .g10_neg (g10_neg),
      .g11_neg (g11_neg)
   );

endmodule

/* bench/tb_order_control.sv */
/*
 * Testbench for the order and tank clear control.
 * Directed tests of the digit strobes and of the T, U and H transfer
 * sequences, checked against a minor-cycle phase kept in the bench.
 */
`timescale 1ns/1ps

module tb_order_control;

   localparam int MINOR          = ccu_pkg::DIGITS_PER_MINOR;  // Digits per minor cycle.
   localparam int MAJOR          = 2 * MINOR;                  // Even plus odd minor cycle.
   localparam int TIMEOUT_CYCLES = 2000;                       // About three times the tests.

   logic                 clk;
   logic                 rst_n;
   logic                 order_load;
   ccu_pkg::order_code_t order_code;
   logic                 r2;
   logic                 s2;
   logic                 ev_d0;
   logic                 odd_d0;
   logic                 ep6;
   logic                 ep7;
   logic                 g9_neg;
   logic                 g10_neg;
   logic                 g11_neg;

   int                   phase;        // Expected digit position in the even/odd pair.
   int                   cycle_count;  // Clock cycles since time 0.
   integer               seed;         // State of $random.

   order_control_top order_control_top_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .order_load (order_load),
      .order_code (order_code),
      .r2         (r2),
      .s2         (s2),
      .ev_d0      (ev_d0),
      .odd_d0     (odd_d0),
      .ep6        (ep6),
      .ep7        (ep7),
      .g9_neg     (g9_neg),
      .g10_neg    (g10_neg),
      .g11_neg    (g11_neg)
   );

   // 4 ns digit clock.
   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Reference phase. Position 0 is even digit 0, MINOR is odd digit 0.
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase <= 0;
      end else begin
         phase <= (phase == MAJOR - 1) ? 0 : phase + 1;  // Wrap after the odd cycle.
      end
   end

   // Run limit.
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Simulation stopped by timeout");
      end
   end

   // Compare a value with its expected value, stop at the first mismatch.
   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Gates and end pulses in the current cycle.
   task automatic check_outputs(input logic exp_g9, input logic exp_g10, input logic exp_g11,
                                input logic exp_ep6, input logic exp_ep7);
      check_value("g9_neg", 32'(g9_neg), 32'(exp_g9));
      check_value("g10_neg", 32'(g10_neg), 32'(exp_g10));
      check_value("g11_neg", 32'(g11_neg), 32'(exp_g11));
      check_value("ep6", 32'(ep6), 32'(exp_ep6));
      check_value("ep7", 32'(ep7), 32'(exp_ep7));
   endtask

   // Strobes follow the reference phase in every cycle out of reset.
   always @(negedge clk) begin
      if (rst_n) begin
         check_value("ev_d0", 32'(ev_d0), 32'(phase == 0));
         check_value("odd_d0", 32'(odd_d0), 32'(phase == MINOR));
      end
   end

   // One-cycle load strobe, ends at mid-cycle with the order held.
   task automatic load_order(input ccu_pkg::order_code_t code);
      @(posedge clk);
      order_load <= 1'b1;
      order_code <= code;
      @(posedge clk);
      order_load <= 1'b0;
      @(negedge clk);
   endtask

   // Random idle gap, then a one-cycle r2 and/or s2 pulse.
   task automatic pulse_stimulus(input logic use_r2, input logic use_s2);
      int gap;
      gap = 1 + ($unsigned($random(seed)) % 20);  // 1 to 20 idle cycles.
      repeat (gap) @(negedge clk);
      @(posedge clk);
      r2 <= use_r2;
      s2 <= use_s2;
      @(negedge clk);
   endtask

   // One transfer sequence with the expected gates and end pulse.
   task automatic run_transfer(input ccu_pkg::order_code_t code,
                               input logic use_r2, input logic use_s2,
                               input logic clr_acc, input logic clr_mult,
                               input logic end6, input logic end7,
                               input logic extra_r2);
      int   wait_odd;   // Cycles from the stimulus to the odd digit 0 that opens the window.
      int   last_k;     // Last cycle of the window, the even digit 0.
      int   extra_k;    // Cycle of the repeated r2, 0 for none.
      int   k;
      logic in_win;
      logic at_end;
      load_order(code);
      pulse_stimulus(use_r2, use_s2);
      check_outputs(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);  // Nothing yet in the stimulus cycle.
      wait_odd = (MINOR - phase + MAJOR) % MAJOR;
      if (wait_odd == 0) begin
         wait_odd = MAJOR;  // This odd digit 0 is too early for the flop.
      end
      last_k  = wait_odd + MINOR;
      extra_k = extra_r2 ? last_k : 0;  // Closing cycle, both flops still set.
      // Run on past the next odd digit 0, where a re-armed flop would open a second window.
      for (k = 1; k <= last_k + MINOR + 2; k++) begin
         @(posedge clk);
         r2 <= (k == extra_k);
         s2 <= 1'b0;
         @(negedge clk);
         in_win = (k > wait_odd) && (k <= last_k);  // Cycle after odd digit 0 to even digit 0.
         at_end = (k == last_k);
         if (at_end) begin
            check_value("ev_d0 at window end", 32'(ev_d0), 32'd1);
         end
         check_outputs(~(in_win & clr_acc), ~(in_win & clr_mult), ~in_win,
                       at_end & end6, at_end & end7);
      end
   endtask

   task automatic test_reset_strobes;
      int k;
      $display("Test: reset and digit strobes");
      for (k = 0; k <= MAJOR; k++) begin
         @(negedge clk);
         check_value("ev_d0", 32'(ev_d0), 32'(k == 0 || k == MAJOR));  // Even digit 0 twice.
         check_value("odd_d0", 32'(odd_d0), 32'(k == MINOR));
         check_outputs(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);                 // All idle.
      end
   endtask

   task automatic test_t_order;
      $display("Test: T order with r2");
      run_transfer(ccu_pkg::ORD_T, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
   endtask

   task automatic test_u_order;
      $display("Test: U order with r2");
      run_transfer(ccu_pkg::ORD_U, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic test_h_order;
      $display("Test: H order with s2");
      run_transfer(ccu_pkg::ORD_H, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic test_no_transfer;
      int k;
      $display("Test: A order ignores r2 and s2");
      load_order(ccu_pkg::ORD_A);
      pulse_stimulus(1'b1, 1'b1);
      for (k = 0; k < 2 * MAJOR; k++) begin
         @(posedge clk);
         r2 <= 1'b0;
         s2 <= 1'b0;
         @(negedge clk);
         check_outputs(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);  // No clear, no end pulse.
      end
   endtask

   task automatic test_repeat_r2;
      $display("Test: repeated r2 during a T sequence");
      run_transfer(ccu_pkg::ORD_T, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
   endtask

   initial begin
      seed        = 93492;
      cycle_count = 0;
      rst_n       = 1'b0;
      order_load  = 1'b0;
      order_code  = ccu_pkg::ORD_NONE;
      r2          = 1'b0;
      s2          = 1'b0;
      repeat (5) @(posedge clk);  // Reset held for 5 cycles.
      rst_n <= 1'b1;
      test_reset_strobes();
      test_t_order();
      test_u_order();
      test_h_order();
      test_no_transfer();
      test_repeat_r2();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* list.f */
verilog/ccu_pkg.sv
verilog/digit_timer.sv
verilog/order_decode.sv
verilog/tank_clear_control.sv
verilog/order_control_top.sv
bench/tb_order_control.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the order control testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

TOP=tb_order_control
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f list.f --top-module "$TOP" -Mdir "$OBJ_DIR"
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Build failed with status $build_status"
   exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
   echo "Simulation ended without a result line"
   exit 1
fi

echo "Simulation passed"
exit 0
